/* files.f */
verilog/xu1_pkg.sv
verilog/xu1_cfg.sv
verilog/xu1_dec.sv
verilog/xu1_byp.sv
verilog/xu1_alu.sv
verilog/xu1_top.sv
verif/xu1_tb.sv

/* run.sh */
#!/bin/bash
# Build the xu1 testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --timescale 1ns/10ps --top-module xu1_tb -f files.f -o xu1_sim \
   && ./obj_dir/xu1_sim > sim.log 2>&1
grep -q "^TEST OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* verif/xu1_tb.sv */
// Testbench for the second fixed-point pipe that replays the trace and checks each writeback
`timescale 1ns/10ps
module xu1_tb;

   localparam int clk_period = 100;
   localparam int wb_lat     = 3;

   logic              nclk;
   logic              arst_n;
   xu1_pkg::issue_t   issue;
   xu1_pkg::wb_t      wb;
   logic              psel;
   logic              penable;
   logic              pwrite;
   logic [3:0]        paddr;
   logic [31:0]       pwdata;
   logic [31:0]       prdata;
   logic              pready;
   logic              pslverr;

   xu1_pkg::wb_t      exp_q[$];
   int                due_q[$];
   int                ncyc = 0;
   int                trace_lines = 0;
   integer            seed;

   xu1_top uut (
      .nclk(nclk),
      .arst_n(arst_n),
      .issue(issue),
      .wb(wb),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr)
   );

   initial begin
      nclk = 1'b0;
      forever #(clk_period / 2) nclk = ~nclk;
   end

   task automatic fail_run();
      $display("TEST FAILED");
      $fatal(1);
   endtask

   task automatic report_mismatch(input string name, input logic [31:0] got,
                                  input logic [31:0] want);
      $display("ERROR %s got 0x%h expected 0x%h", name, got, want);
      fail_run();
   endtask

   task automatic check_wb(input xu1_pkg::wb_t got, input xu1_pkg::wb_t want);
      if (got.valid !== want.valid) report_mismatch("wb.valid", 32'(got.valid), 32'(want.valid));
      if (got.itag !== want.itag) report_mismatch("wb.itag", 32'(got.itag), 32'(want.itag));
      if (got.gpr_we !== want.gpr_we)
         report_mismatch("wb.gpr_we", 32'(got.gpr_we), 32'(want.gpr_we));
      if (got.gpr_wa !== want.gpr_wa)
         report_mismatch("wb.gpr_wa", 32'(got.gpr_wa), 32'(want.gpr_wa));
      if (got.gpr_wd !== want.gpr_wd) report_mismatch("wb.gpr_wd", got.gpr_wd, want.gpr_wd);
      if (got.cr_we !== want.cr_we) report_mismatch("wb.cr_we", 32'(got.cr_we), 32'(want.cr_we));
      if (got.cr !== want.cr) report_mismatch("wb.cr", 32'(got.cr), 32'(want.cr));
      if (got.ca_we !== want.ca_we) report_mismatch("wb.ca_we", 32'(got.ca_we), 32'(want.ca_we));
      if (got.ca !== want.ca) report_mismatch("wb.ca", 32'(got.ca), 32'(want.ca));
      if (got.stq_val !== want.stq_val)
         report_mismatch("wb.stq_val", 32'(got.stq_val), 32'(want.stq_val));
      if (got.dvc1_cmp !== want.dvc1_cmp)
         report_mismatch("wb.dvc1_cmp", 32'(got.dvc1_cmp), 32'(want.dvc1_cmp));
      if (got.dvc2_cmp !== want.dvc2_cmp)
         report_mismatch("wb.dvc2_cmp", 32'(got.dvc2_cmp), 32'(want.dvc2_cmp));
   endtask

   task automatic check_apb(input logic [31:0] got_rdata, input logic got_err,
                            input logic got_ready, input logic [31:0] want_rdata,
                            input logic want_err);
      if (got_ready !== 1'b1) report_mismatch("pready", 32'(got_ready), 32'h1);
      if (got_rdata !== want_rdata) report_mismatch("prdata", got_rdata, want_rdata);
      if (got_err !== want_err) report_mismatch("pslverr", 32'(got_err), 32'(want_err));
   endtask

   // Setup phase, then access phase sampled mid-cycle, released at the edge that ends it
   task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] data,
                             input logic err);
      logic [31:0] want_rdata;
      want_rdata = wr ? 32'h0 : data;
      @(posedge nclk);
      issue   <= '0;
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= wr;
      paddr   <= addr;
      pwdata  <= wr ? data : 32'h0;
      @(posedge nclk);
      penable <= 1'b1;
      @(negedge nclk);
      check_apb(prdata, pslverr, pready, want_rdata, err);
      @(posedge nclk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   // The record shows up three edges after the drive edge and is sampled at the next negedge
   task automatic issue_op(input xu1_pkg::issue_t rec, input xu1_pkg::wb_t want, input int gap);
      repeat (gap) begin
         @(posedge nclk);
         issue <= '0;
      end
      @(posedge nclk);
      issue <= rec;
      exp_q.push_back(want);
      due_q.push_back(ncyc + wb_lat + 1);
   endtask

   always @(negedge nclk) begin
      ncyc = ncyc + 1;
      if (due_q.size() > 0 && due_q[0] == ncyc) begin
         check_wb(wb, exp_q[0]);
         void'(exp_q.pop_front());
         void'(due_q.pop_front());
      end else if (wb.valid) begin
         report_mismatch("wb.valid", 32'(wb.valid), 32'h0);
      end
   end

   initial begin
      wait (trace_lines > 0);
      #((trace_lines + 32) * clk_period * 4);
      $display("Watchdog expired before the trace finished");
      fail_run();
   end

   initial begin : main
      int              fd;
      int              rc;
      int              g;
      string           line;
      string           rest;
      string           trace_q[$];
      logic [31:0]     gap, instr, itag, rs1, rs2, we, wa, wd, crwe, cr, cawe, ca, stq, d1, d2;
      logic [31:0]     wr, addr, data, err;
      xu1_pkg::issue_t rec;
      xu1_pkg::wb_t    want;

      seed    = 89;
      arst_n  = 1'b0;
      issue   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      paddr   = 4'h0;
      pwdata  = 32'h0;

      fd = $fopen("verif/xu1_trace.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the trace file verif/xu1_trace.txt");
         fail_run();
      end
      while (!$feof(fd)) begin
         line = "";
         rc = $fgets(line, fd);
         if (rc > 0 && line.getc(0) != "#" && line.getc(0) != "\n") begin
            trace_q.push_back(line);
         end
      end
      $fclose(fd);
      trace_lines = trace_q.size();

      repeat (16) @(posedge nclk);
      arst_n <= 1'b1;

      foreach (trace_q[i]) begin
         line = trace_q[i];
         rest = line.substr(1, line.len() - 1);
         if (line.getc(0) == "A") begin
            rc = $sscanf(rest, "%h %h %h %h", wr, addr, data, err);
            if (rc != 4) begin
               $display("Malformed APB line in the trace: %s", line);
               fail_run();
            end
            apb_access(wr[0], addr[3:0], data, err[0]);
         end else if (line.getc(0) == "I") begin
            rc = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h", gap, instr,
                         itag, rs1, rs2, we, wa, wd, crwe, cr, cawe, ca, stq, d1, d2);
            if (rc != 15) begin
               $display("Malformed issue line in the trace: %s", line);
               fail_run();
            end
            rec          = '0;
            rec.valid    = 1'b1;
            rec.instr    = instr;
            rec.itag     = itag[5:0];
            rec.rs1_data = rs1;
            rec.rs2_data = rs2;
            want          = '0;
            want.valid    = 1'b1;
            want.itag     = itag[5:0];
            want.gpr_we   = we[0];
            want.gpr_wa   = wa[4:0];
            want.gpr_wd   = wd;
            want.cr_we    = crwe[0];
            want.cr       = cr[3:0];
            want.ca_we    = cawe[0];
            want.ca       = ca[0];
            want.stq_val  = stq[0];
            want.dvc1_cmp = d1[3:0];
            want.dvc2_cmp = d2[3:0];
            // A gap of f asks for a random number of idle cycles
            if (gap == 32'hf) begin
               g = $random(seed) & 3;
            end else begin
               g = gap;
            end
            issue_op(rec, want, g);
         end else begin
            $display("Unknown line kind in the trace: %s", line);
            fail_run();
         end
      end

      @(posedge nclk);
      issue <= '0;
      for (int i = 0; i < 8 && due_q.size() != 0; i++) begin
         @(negedge nclk);
      end
      @(negedge nclk);
      if (due_q.size() == 0) begin
         $display("TEST OK");
         $finish;
      end else begin
         $display("Writebacks still outstanding at the end of the trace");
         fail_run();
      end
   end

endmodule

/* verif/xu1_trace.txt */
# A rw addr data err   (rw 1 is a write, data is write data or expected read data)
# I gap instr itag rs1 rs2 gpr_we gpr_wa gpr_wd cr_we cr ca_we ca stq_val dvc1 dvc2 (gap f random)
A 0 0 00000000 0
A 0 4 00000000 0
A 1 0 11223344 0
A 1 4 a5a5a5a5 0
A 0 0 11223344 0
A 0 4 a5a5a5a5 0
A 1 8 deadbeef 1
A 0 8 00000000 1
I f 7d411214 01 7fffffff 00000001 1 0a 80000000 0 0 1 0 0 0 0
I f 7d632214 02 ffffffff 00000002 1 0b 00000001 0 0 1 1 0 0 0
I f 3981fffc 03 00001000 12345678 1 0c 00000ffc 0 0 0 0 0 0 0
I f 39a01234 04 deadbeef 12345678 1 0d 00001234 0 0 0 0 0 0 0
I f 7dc53050 05 00000003 0000000a 1 0e 00000007 0 0 1 1 0 0 0
I f 7de74050 06 00000005 00000002 1 0f fffffffd 0 0 1 0 0 0 0
I f 7e011038 07 f0f0ff00 0ff00ff0 1 10 00f00f00 0 0 0 0 0 0 0
I f 7e232378 08 f0f0ff00 0ff00ff0 1 11 fff0fff0 0 0 0 0 0 0 0
I f 7e453278 09 f0f0ff00 0ff00ff0 1 12 ff00f0f0 0 0 0 0 0 0 0
I f 7c011000 0a ffffffff 00000001 0 00 00000000 1 8 0 0 0 0 0
I f 7c032000 0b 00000005 80000000 0 00 00000000 1 4 0 0 0 0 0
I f 7c053000 0c 12345678 12345678 0 00 00000000 1 2 0 0 0 0 0
I f 3a800100 0d 00000000 00000000 1 14 00000100 0 0 0 0 0 0 0
I 0 7eb4a214 0e 55555555 55555555 1 15 00000200 0 0 1 0 0 0 0
I 1 7ed4ab78 0f 00000100 55555555 1 16 00000300 0 0 0 0 0 0 0
I f 3ae00011 10 00000000 00000000 1 17 00000011 0 0 0 0 0 0 0
I 0 3ae00022 11 00000000 00000000 1 17 00000022 0 0 0 0 0 0 0
I 0 7f17ba14 12 77777777 77777777 1 18 00000044 0 0 1 0 0 0 0
I f 91280010 13 00002000 11223344 0 09 00002010 0 0 0 0 1 f 0
I f 90e6fff8 14 00003000 a5223399 0 07 00002ff8 0 0 0 0 1 6 8
I f 90a00000 15 ffffffff 00000000 0 05 00000000 0 0 0 0 1 0 0

/* verilog/xu1_alu.sv */
// Adder, logic, compare and store data compare stage producing the ex3 writeback
`timescale 1ns/10ps
module xu1_alu (
   input  logic                              nclk,
   input  logic                              arst_n,
   input  xu1_pkg::ctl_t                     ctl,
   input  logic [xu1_pkg::gpr_width-1:0]     rs1,
   input  logic [xu1_pkg::gpr_width-1:0]     rs2,
   input  logic [xu1_pkg::gpr_width-1:0]     dvc1,
   input  logic [xu1_pkg::gpr_width-1:0]     dvc2,
   output xu1_pkg::fwd_t                     fwd_ex2,
   output xu1_pkg::fwd_t                     fwd_ex3,
   output xu1_pkg::wb_t                      wb
);

   xu1_pkg::ctl_t                    ex2_ctl;
   logic                             is_sub;
   logic                             is_st;
   logic [xu1_pkg::gpr_width-1:0]    add_a;
   logic [xu1_pkg::gpr_width-1:0]    add_b;
   logic [xu1_pkg::gpr_width-1:0]    add_sum;
   logic                             add_co;
   logic [xu1_pkg::gpr_width-1:0]    result;
   logic [3:0]                       cr;
   logic [xu1_pkg::gpr_bytes-1:0]    dvc1_cmp;
   logic [xu1_pkg::gpr_bytes-1:0]    dvc2_cmp;

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex2_ctl <= '0;
      end else begin
         ex2_ctl <= ctl;
      end
   end

   always_comb begin
      is_sub = (ex2_ctl.op == xu1_pkg::alu_sub);
      is_st  = (ex2_ctl.op == xu1_pkg::alu_store);
      // subf is ~ra + rb + 1, stores form base plus displacement
      add_a = is_sub ? ~rs1 : rs1;
      add_b = is_st ? ex2_ctl.imm : rs2;
      {add_co, add_sum} = {1'b0, add_a} + {1'b0, add_b} + {{xu1_pkg::gpr_width{1'b0}}, is_sub};
      case (ex2_ctl.op)
         xu1_pkg::alu_add,
         xu1_pkg::alu_sub,
         xu1_pkg::alu_store: result = add_sum;
         xu1_pkg::alu_and:   result = rs1 & rs2;
         xu1_pkg::alu_or:    result = rs1 | rs2;
         xu1_pkg::alu_xor:   result = rs1 ^ rs2;
         default:            result = '0;
      endcase
      cr = {$signed(rs1) < $signed(rs2), $signed(rs1) > $signed(rs2), rs1 == rs2, 1'b0};
      for (int i = 0; i < xu1_pkg::gpr_bytes; i++) begin
         dvc1_cmp[i] = (rs2[8*i +: 8] == dvc1[8*i +: 8]);
         dvc2_cmp[i] = (rs2[8*i +: 8] == dvc2[8*i +: 8]);
      end
   end

   always_comb begin
      fwd_ex2.valid = ex2_ctl.valid && ex2_ctl.gpr_we;
      fwd_ex2.rt    = ex2_ctl.rt;
      fwd_ex2.data  = result;
      fwd_ex3.valid = wb.valid && wb.gpr_we;
      fwd_ex3.rt    = wb.gpr_wa;
      fwd_ex3.data  = wb.gpr_wd;
   end

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         wb <= '0;
      end else begin
         wb.valid    <= ex2_ctl.valid;
         wb.itag     <= ex2_ctl.itag;
         wb.gpr_we   <= ex2_ctl.gpr_we;
         wb.gpr_wa   <= ex2_ctl.rt;
         wb.gpr_wd   <= result;
         wb.cr_we    <= ex2_ctl.cr_we;
         wb.cr       <= ex2_ctl.cr_we ? cr : 4'b0;
         wb.ca_we    <= ex2_ctl.ca_we;
         wb.ca       <= ex2_ctl.ca_we && add_co;
         wb.stq_val  <= ex2_ctl.valid && is_st;
         wb.dvc1_cmp <= is_st ? dvc1_cmp : '0;
         wb.dvc2_cmp <= is_st ? dvc2_cmp : '0;
      end
   end

endmodule

/* verilog/xu1_byp.sv */
// Operand bypass selecting forwarded, zero or immediate values for the ex2 operands
`timescale 1ns/10ps
module xu1_byp (
   input  logic                              nclk,
   input  logic                              arst_n,
   input  xu1_pkg::ctl_t                     ctl,
   input  logic [xu1_pkg::gpr_width-1:0]     issue_rs1,
   input  logic [xu1_pkg::gpr_width-1:0]     issue_rs2,
   input  xu1_pkg::fwd_t                     fwd_ex2,
   input  xu1_pkg::fwd_t                     fwd_ex3,
   output logic [xu1_pkg::gpr_width-1:0]     rs1,
   output logic [xu1_pkg::gpr_width-1:0]     rs2
);

   logic [xu1_pkg::gpr_width-1:0] ex1_rs1_rf;
   logic [xu1_pkg::gpr_width-1:0] ex1_rs2_rf;
   logic [xu1_pkg::gpr_width-1:0] ex1_rs1;
   logic [xu1_pkg::gpr_width-1:0] ex1_rs2;

   // The younger producer in ex2 takes priority over ex3
   function automatic logic [xu1_pkg::gpr_width-1:0] pick_src(
      input logic [xu1_pkg::gpr_enc-1:0]   src,
      input logic [xu1_pkg::gpr_width-1:0] rf_val,
      input xu1_pkg::fwd_t                 f2,
      input xu1_pkg::fwd_t                 f3
   );
      logic [xu1_pkg::gpr_width-1:0] val;
      val = rf_val;
      if (f2.valid && f2.rt == src) begin
         val = f2.data;
      end else if (f3.valid && f3.rt == src) begin
         val = f3.data;
      end
      return val;
   endfunction

   // Register file data arrives with the issue and lines up with ex1 here
   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ex1_rs1_rf <= '0;
         ex1_rs2_rf <= '0;
      end else begin
         ex1_rs1_rf <= issue_rs1;
         ex1_rs2_rf <= issue_rs2;
      end
   end

   always_comb begin
      if (ctl.rs1_zero) begin
         ex1_rs1 = '0;
      end else begin
         ex1_rs1 = pick_src(ctl.ra, ex1_rs1_rf, fwd_ex2, fwd_ex3);
      end
      // Stores keep their data on rs2 and the ALU adds the displacement itself
      if (ctl.use_imm && ctl.op != xu1_pkg::alu_store) begin
         ex1_rs2 = ctl.imm;
      end else begin
         ex1_rs2 = pick_src(ctl.rb, ex1_rs2_rf, fwd_ex2, fwd_ex3);
      end
   end

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         rs1 <= '0;
         rs2 <= '0;
      end else begin
         rs1 <= ex1_rs1;
         rs2 <= ex1_rs2;
      end
   end

endmodule

/* verilog/xu1_cfg.sv */
// APB register block holding the two data value compare registers for stores
`timescale 1ns/10ps
module xu1_cfg (
   input  logic                              nclk,
   input  logic                              arst_n,
   input  logic                              psel,
   input  logic                              penable,
   input  logic                              pwrite,
   input  logic [3:0]                        paddr,
   input  logic [31:0]                       pwdata,
   output logic [31:0]                       prdata,
   output logic                              pready,
   output logic                              pslverr,
   output logic [xu1_pkg::gpr_width-1:0]     dvc1,
   output logic [xu1_pkg::gpr_width-1:0]     dvc2
);

   logic access;
   logic hit1;
   logic hit2;

   assign access = psel && penable;
   assign hit1   = (paddr == xu1_pkg::dvc1_addr);
   assign hit2   = (paddr == xu1_pkg::dvc2_addr);

   // No wait states
   assign pready  = 1'b1;
   assign pslverr = access && !(hit1 || hit2);

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         dvc1 <= '0;
         dvc2 <= '0;
      end else if (access && pwrite) begin
         if (hit1) begin
            dvc1 <= pwdata;
         end
         if (hit2) begin
            dvc2 <= pwdata;
         end
      end
   end

   // Unmapped reads return zero
   always_comb begin
      prdata = '0;
      if (access && !pwrite) begin
         if (hit1) begin
            prdata = dvc1;
         end else if (hit2) begin
            prdata = dvc2;
         end
      end
   end

endmodule

/* verilog/xu1_dec.sv */
// Instruction decoder turning the issued word into ex1 control and target registers
`timescale 1ns/10ps
module xu1_dec (
   input  logic              nclk,
   input  logic              arst_n,
   input  xu1_pkg::issue_t   issue,
   output xu1_pkg::ctl_t     ctl
);

   xu1_pkg::ctl_t ex0_ctl;

   always_comb begin
      ex0_ctl = '0;
      if (issue.valid) begin
         ex0_ctl.valid = 1'b1;
         ex0_ctl.itag  = issue.itag;
         // Unknown opcodes fall through as a compare with every write enable off
         ex0_ctl.op    = xu1_pkg::alu_cmp;
         ex0_ctl.ra    = issue.instr.d.ra;
         ex0_ctl.rt    = issue.instr.d.rt;
         ex0_ctl.imm   = {{16{issue.instr.d.si[15]}}, issue.instr.d.si};
         case (issue.instr.d.opcd)
            xu1_pkg::op_addi: begin
               ex0_ctl.op       = xu1_pkg::alu_add;
               ex0_ctl.use_imm  = 1'b1;
               ex0_ctl.rs1_zero = (issue.instr.d.ra == '0);
               ex0_ctl.gpr_we   = 1'b1;
            end
            xu1_pkg::op_stw: begin
               // The rs field names the store data and travels down the rb path
               ex0_ctl.op       = xu1_pkg::alu_store;
               ex0_ctl.use_imm  = 1'b1;
               ex0_ctl.rs1_zero = (issue.instr.d.ra == '0);
               ex0_ctl.rb       = issue.instr.d.rt;
            end
            xu1_pkg::op_xform: begin
               ex0_ctl.rb = issue.instr.x.rb;
               case (issue.instr.x.xo)
                  xu1_pkg::xo_add: begin
                     ex0_ctl.op     = xu1_pkg::alu_add;
                     ex0_ctl.gpr_we = 1'b1;
                     ex0_ctl.ca_we  = 1'b1;
                  end
                  xu1_pkg::xo_subf: begin
                     ex0_ctl.op     = xu1_pkg::alu_sub;
                     ex0_ctl.gpr_we = 1'b1;
                     ex0_ctl.ca_we  = 1'b1;
                  end
                  xu1_pkg::xo_and: begin
                     ex0_ctl.op     = xu1_pkg::alu_and;
                     ex0_ctl.gpr_we = 1'b1;
                  end
                  xu1_pkg::xo_or: begin
                     ex0_ctl.op     = xu1_pkg::alu_or;
                     ex0_ctl.gpr_we = 1'b1;
                  end
                  xu1_pkg::xo_xor: begin
                     ex0_ctl.op     = xu1_pkg::alu_xor;
                     ex0_ctl.gpr_we = 1'b1;
                  end
                  xu1_pkg::xo_cmp: begin
                     ex0_ctl.cr_we = 1'b1;
                  end
                  default: begin
                  end
               endcase
            end
            default: begin
            end
         endcase
      end
   end

   always_ff @(posedge nclk or negedge arst_n) begin
      if (!arst_n) begin
         ctl <= '0;
      end else begin
         ctl <= ex0_ctl;
      end
   end

endmodule

/* verilog/xu1_pkg.sv */
// Shared widths, opcodes and pipeline records of the second fixed-point execution pipe
package xu1_pkg;

   localparam int gpr_width  = 32;
   localparam int gpr_bytes  = gpr_width / 8;
   localparam int itag_width = 6;
   localparam int gpr_enc    = 5;

   localparam logic [5:0] op_addi  = 6'd14;
   localparam logic [5:0] op_stw   = 6'd36;
   localparam logic [5:0] op_xform = 6'd31;

   localparam logic [9:0] xo_cmp  = 10'd0;
   localparam logic [9:0] xo_subf = 10'd40;
   localparam logic [9:0] xo_and  = 10'd28;
   localparam logic [9:0] xo_add  = 10'd266;
   localparam logic [9:0] xo_xor  = 10'd316;
   localparam logic [9:0] xo_or   = 10'd444;

   localparam logic [3:0] dvc1_addr = 4'h0;
   localparam logic [3:0] dvc2_addr = 4'h4;

   // Field order follows the ISA, so opcd sits in the most significant bits
   typedef struct packed {
      logic [5:0]         opcd;
      logic [gpr_enc-1:0] rt;
      logic [gpr_enc-1:0] ra;
      logic [15:0]        si;
   } instr_d_t;

   typedef struct packed {
      logic [5:0]         opcd;
      logic [gpr_enc-1:0] rt;
      logic [gpr_enc-1:0] ra;
      logic [gpr_enc-1:0] rb;
      logic [9:0]         xo;
      logic               rc;
   } instr_x_t;

   typedef union packed {
      instr_d_t d;
      instr_x_t x;
   } instr_u;

   typedef enum logic [2:0] {
      alu_add,
      alu_sub,
      alu_and,
      alu_or,
      alu_xor,
      alu_cmp,
      alu_store
   } alu_op_e;

   typedef struct packed {
      logic                  valid;
      instr_u                instr;
      logic [itag_width-1:0] itag;
      logic [gpr_width-1:0]  rs1_data;
      logic [gpr_width-1:0]  rs2_data;
   } issue_t;

   typedef struct packed {
      logic                  valid;
      logic [itag_width-1:0] itag;
      alu_op_e               op;
      logic                  use_imm;
      logic                  rs1_zero;
      logic [gpr_width-1:0]  imm;
      logic [gpr_enc-1:0]    ra;
      logic [gpr_enc-1:0]    rb;
      logic [gpr_enc-1:0]    rt;
      logic                  gpr_we;
      logic                  cr_we;
      logic                  ca_we;
   } ctl_t;

   typedef struct packed {
      logic                 valid;
      logic [gpr_enc-1:0]   rt;
      logic [gpr_width-1:0] data;
   } fwd_t;

   // CR field bits from msb down are lt, gt, eq, so
   typedef struct packed {
      logic                  valid;
      logic [itag_width-1:0] itag;
      logic                  gpr_we;
      logic [gpr_enc-1:0]    gpr_wa;
      logic [gpr_width-1:0]  gpr_wd;
      logic                  cr_we;
      logic [3:0]            cr;
      logic                  ca_we;
      logic                  ca;
      logic                  stq_val;
      logic [gpr_bytes-1:0]  dvc1_cmp;
      logic [gpr_bytes-1:0]  dvc2_cmp;
   } wb_t;

endpackage

/* verilog/xu1_top.sv */
// Second fixed-point pipe top level joining register block, decode, bypass and ALU
`timescale 1ns/10ps
module xu1_top (
   input  logic                  nclk,
   input  logic                  arst_n,

   input  xu1_pkg::issue_t       issue,
   output xu1_pkg::wb_t          wb,

   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [3:0]            paddr,
   input  logic [31:0]           pwdata,
   output logic [31:0]           prdata,
   output logic                  pready,
   output logic                  pslverr
);

   xu1_pkg::ctl_t                    ctl;
   xu1_pkg::fwd_t                    fwd_ex2;
   xu1_pkg::fwd_t                    fwd_ex3;
   logic [xu1_pkg::gpr_width-1:0]    rs1;
   logic [xu1_pkg::gpr_width-1:0]    rs2;
   logic [xu1_pkg::gpr_width-1:0]    dvc1;
   logic [xu1_pkg::gpr_width-1:0]    dvc2;

   xu1_cfg cfg (
      .nclk(nclk),
      .arst_n(arst_n),
      .psel(psel),
      .penable(penable),
      .pwrite(pwrite),
      .paddr(paddr),
      .pwdata(pwdata),
      .prdata(prdata),
      .pready(pready),
      .pslverr(pslverr),
      .dvc1(dvc1),
      .dvc2(dvc2)
   );

   xu1_dec dec (
      .nclk(nclk),
      .arst_n(arst_n),
      .issue(issue),
      .ctl(ctl)
   );

   xu1_byp byp (
      .nclk(nclk),
      .arst_n(arst_n),
      .ctl(ctl),
      .issue_rs1(issue.rs1_data),
      .issue_rs2(issue.rs2_data),
      .fwd_ex2(fwd_ex2),
      .fwd_ex3(fwd_ex3),
      .rs1(rs1),
      .rs2(rs2)
   );

   xu1_alu alu (
      .nclk(nclk),
      .arst_n(arst_n),
      .ctl(ctl),
      .rs1(rs1),
      .rs2(rs2),
      .dvc1(dvc1),
      .dvc2(dvc2),
      .fwd_ex2(fwd_ex2),
      .fwd_ex3(fwd_ex3),
      .wb(wb)
   );

endmodule
